/* run_sim.sh */
#!/bin/sh
# Build and run the laser link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f sources.f --top-module laser_link_tb -o laser_link_sim

./obj_dir/laser_link_sim | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* sources.f */
src/laser_link_pkg.sv
src/laser_transmitter.sv
src/laser_receiver.sv
src/lane_pair_assembler.sv
src/rx_queue.sv
src/laser_link.sv
tests/laser_link_properties.sv
tests/laser_link_tb.sv

/* src/lane_pair_assembler.sv */
`timescale 1ns/10ps

module lane_pair_assembler
    import laser_link_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       lane1_valid,
    input  logic       lane2_valid,
    input  byte_t      lane1_byte,
    input  byte_t      lane2_byte,
    output logic       pair_valid,
    output lane_pair_t pair_data
);

    logic  pending1;
    logic  pending2;
    logic  both_ready;
    byte_t byte1_q;
    byte_t byte2_q;

    // Same-cycle arrivals count as pending
    assign both_ready = (pending1 || lane1_valid) && (pending2 || lane2_valid);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending1   <= 1'b0;
            pending2   <= 1'b0;
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= both_ready;
            pending1   <= !both_ready && (pending1 || lane1_valid);
            pending2   <= !both_ready && (pending2 || lane2_valid);
        end
    end

    // Newer byte on a lane overwrites a stale one
    always_ff @(posedge clock) begin
        if (lane1_valid) begin
            byte1_q <= lane1_byte;
        end
        if (lane2_valid) begin
            byte2_q <= lane2_byte;
        end
    end

    assign pair_data.lane1 = byte1_q;
    assign pair_data.lane2 = byte2_q;

endmodule

/* src/laser_link.sv */
`timescale 1ns/10ps

module laser_link
    import laser_link_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       send,
    input  lane_pair_t send_pair,
    output logic       busy,
    output logic       laser1_tx,
    output logic       laser2_tx,
    input  logic       laser1_rx,
    input  logic       laser2_rx,
    input  logic       pop,
    output lane_pair_t pair_out,
    output logic       empty,
    output logic       full,
    output logic       overflow
);

    logic       lane1_valid;
    logic       lane2_valid;
    byte_t      lane1_byte;
    byte_t      lane2_byte;
    logic       pair_valid;
    lane_pair_t pair_data;

    laser_transmitter tx_i (
        .clock     (clock),
        .reset     (reset),
        .send      (send),
        .send_pair (send_pair),
        .busy      (busy),
        .laser1_tx (laser1_tx),
        .laser2_tx (laser2_tx)
    );

    // One receiver per line, paired up again afterwards
    laser_receiver lane1_rx_i (
        .clock      (clock),
        .reset      (reset),
        .laser_rx   (laser1_rx),
        .byte_valid (lane1_valid),
        .rx_byte    (lane1_byte)
    );

    laser_receiver lane2_rx_i (
        .clock      (clock),
        .reset      (reset),
        .laser_rx   (laser2_rx),
        .byte_valid (lane2_valid),
        .rx_byte    (lane2_byte)
    );

    lane_pair_assembler assembler_i (
        .clock       (clock),
        .reset       (reset),
        .lane1_valid (lane1_valid),
        .lane2_valid (lane2_valid),
        .lane1_byte  (lane1_byte),
        .lane2_byte  (lane2_byte),
        .pair_valid  (pair_valid),
        .pair_data   (pair_data)
    );

    rx_queue queue_i (
        .clock     (clock),
        .reset     (reset),
        .push      (pair_valid),
        .push_data (pair_data),
        .pop       (pop),
        .pair_out  (pair_out),
        .empty     (empty),
        .full      (full),
        .overflow  (overflow)
    );

endmodule

/* src/laser_link_pkg.sv */
package laser_link_pkg;

    // Link timing, in system clocks
    localparam int BIT_CLOCKS = 8;

    // Sample positions inside a bit that take part in the majority vote
    localparam int VOTE_FIRST = 3;
    localparam int VOTE_LAST  = 5;

    // Start bit, eight data bits, stop bit
    localparam int FRAME_BITS = 10;

    // Receive queue entries, a power of two
    localparam int QUEUE_DEPTH = 16;

    typedef logic [7:0] byte_t;
    typedef logic [3:0] sample_count_t;
    typedef logic [3:0] bit_count_t;

    // Number of high samples seen in the vote window
    typedef logic [1:0] vote_t;

    // Both lanes always travel together
    typedef struct packed {
        byte_t lane1;
        byte_t lane2;
    } lane_pair_t;

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    typedef enum logic {
        RX_IDLE,
        RX_FRAME
    } rx_state_t;

endpackage

/* src/laser_receiver.sv */
`timescale 1ns/10ps

module laser_receiver
    import laser_link_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  laser_rx,
    output logic  byte_valid,
    output byte_t rx_byte
);

    logic          sync1;
    logic          sync2;
    logic          rx_prev;
    logic          rise;
    rx_state_t     state;
    sample_count_t sample_cnt;
    bit_count_t    bit_idx;
    vote_t         votes;
    vote_t         vote_sum;
    logic          in_window;
    logic          bit_end;
    logic          stop_close;
    byte_t         shift_q;

    // Two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sync1   <= 1'b0;
            sync2   <= 1'b0;
            rx_prev <= 1'b0;
        end else begin
            sync1   <= laser_rx;
            sync2   <= sync1;
            rx_prev <= sync2;
        end
    end

    assign rise = sync2 && !rx_prev;

    assign in_window = (sample_cnt >= sample_count_t'(VOTE_FIRST)) &&
                       (sample_cnt <= sample_count_t'(VOTE_LAST));

    // Vote count including the current sample
    assign vote_sum = votes + vote_t'(in_window && sync2);

    assign bit_end = (sample_cnt == sample_count_t'(BIT_CLOCKS - 1));

    // Stop bit is judged as soon as its window closes, which leaves
    // the rest of the stop bit to catch the next start edge
    assign stop_close = (bit_idx == bit_count_t'(FRAME_BITS - 1)) &&
                        (sample_cnt == sample_count_t'(VOTE_LAST));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= RX_IDLE;
            sample_cnt <= '0;
            bit_idx    <= '0;
            votes      <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (rise) begin
                        state      <= RX_FRAME;
                        sample_cnt <= '0;
                        bit_idx    <= '0;
                        votes      <= '0;
                    end
                end
                RX_FRAME: begin
                    if (stop_close) begin
                        state <= RX_IDLE;
                        // A high stop bit drops the frame
                        byte_valid <= !vote_sum[1];
                    end else if (bit_end) begin
                        sample_cnt <= '0;
                        votes      <= '0;
                        bit_idx    <= bit_idx + 1'b1;
                        // Start bit voted low, so it was only a glitch
                        if ((bit_idx == '0) && !votes[1]) begin
                            state <= RX_IDLE;
                        end
                    end else begin
                        sample_cnt <= sample_cnt + 1'b1;
                        votes      <= vote_sum;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first, so shift in from the top
    always_ff @(posedge clock) begin
        if ((state == RX_FRAME) && bit_end && (bit_idx != '0)) begin
            shift_q <= {votes[1], shift_q[7:1]};
        end
    end

    assign rx_byte = shift_q;

endmodule

/* src/laser_transmitter.sv */
`timescale 1ns/10ps

module laser_transmitter
    import laser_link_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       send,
    input  lane_pair_t send_pair,
    output logic       busy,
    output logic       laser1_tx,
    output logic       laser2_tx
);

    tx_state_t     state;
    lane_pair_t    pair_q;
    sample_count_t sample_cnt;
    bit_count_t    bit_idx;
    logic          accept;
    logic          bit_end;
    logic          frame_end;

    // Line level for one bit of a frame
    // Index 0 is the start bit, 1 to 8 carry data LSB first, 9 is the stop bit
    function automatic logic frame_bit(input byte_t data, input bit_count_t idx);
        logic value;
        value = 1'b0;
        if (idx == '0) begin
            value = 1'b1;
        end else if (idx < bit_count_t'(FRAME_BITS - 1)) begin
            value = data[3'(idx - 1'b1)];
        end
        return value;
    endfunction

    assign accept    = send && (state == TX_IDLE);
    assign bit_end   = (sample_cnt == sample_count_t'(BIT_CLOCKS - 1));
    assign frame_end = bit_end && (bit_idx == bit_count_t'(FRAME_BITS - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= TX_IDLE;
            sample_cnt <= '0;
            bit_idx    <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (send) begin
                        state      <= TX_SEND;
                        sample_cnt <= '0;
                        bit_idx    <= '0;
                    end
                end
                TX_SEND: begin
                    if (bit_end) begin
                        sample_cnt <= '0;
                        bit_idx    <= bit_idx + 1'b1;
                        // Last stop-bit cycle, free for the next pair
                        if (frame_end) begin
                            state <= TX_IDLE;
                        end
                    end else begin
                        sample_cnt <= sample_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Pair is held for the whole frame so the host may change send_pair
    always_ff @(posedge clock) begin
        if (accept) begin
            pair_q <= send_pair;
        end
    end

    assign busy = (state == TX_SEND);

    // Both lanes share one bit counter
    assign laser1_tx = busy && frame_bit(pair_q.lane1, bit_idx);
    assign laser2_tx = busy && frame_bit(pair_q.lane2, bit_idx);

endmodule

/* src/rx_queue.sv */
`timescale 1ns/10ps

module rx_queue
    import laser_link_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       push,
    input  lane_pair_t push_data,
    input  logic       pop,
    output lane_pair_t pair_out,
    output logic       empty,
    output logic       full,
    output logic       overflow
);

    lane_pair_t                       mem [QUEUE_DEPTH];
    logic [$clog2(QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(QUEUE_DEPTH):0]     count;
    logic                             do_pop;
    logic                             do_push;

    assign empty = (count == '0);
    // Top bit of the count is only set at QUEUE_DEPTH
    assign full  = count[$clog2(QUEUE_DEPTH)];

    assign do_pop  = pop && !empty;
    // A pop in the same cycle makes room for the push
    assign do_push = push && (!full || do_pop);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            // Sticky until reset
            if (push && !do_push) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Oldest entry falls through to the output
    assign pair_out = mem[rd_ptr];

endmodule

/* tests/laser_link_properties.sv */
`timescale 1ns/10ps

module laser_link_properties (
    input logic clock,
    input logic reset,
    input logic busy,
    input logic laser1_tx,
    input logic laser2_tx,
    input logic empty,
    input logic full,
    input logic overflow
);

    empty_full_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(empty && full)
    ) else $error("Queue shows empty and full at the same time");

    // Overflow only clears on reset
    overflow_sticky: assert property (
        @(posedge clock) disable iff (reset) overflow |=> overflow
    ) else $error("overflow fell without a reset");

    // Lines stay dark between frames
    idle_lines_low: assert property (
        @(posedge clock) disable iff (reset) !busy |-> (!laser1_tx && !laser2_tx)
    ) else $error("A laser line is high while the transmitter is idle");

endmodule

bind laser_link laser_link_properties properties_i (
    .clock     (clock),
    .reset     (reset),
    .busy      (busy),
    .laser1_tx (laser1_tx),
    .laser2_tx (laser2_tx),
    .empty     (empty),
    .full      (full),
    .overflow  (overflow)
);

/* tests/laser_link_tb.sv */
`timescale 1ns/10ps

module laser_link_tb
    import laser_link_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 12000;
    localparam int LOOPBACK_PAIRS = 30;
    localparam int FLOOD_PAIRS    = 20;

    logic        clock;
    logic        reset;
    logic        send;
    lane_pair_t  send_pair;
    logic        busy;
    logic        laser1_tx;
    logic        laser2_tx;
    logic        laser1_rx;
    logic        laser2_rx;
    logic        pop = 1'b0;
    lane_pair_t  pair_out;
    logic        empty;
    logic        full;
    logic        overflow;

    // Per-lane fault injection on the loopback path
    logic        force1;
    logic        force2;

    lane_pair_t  model_q[$];
    lane_pair_t  expected;
    logic        pop_enable;
    logic        can_pop = 1'b0;
    int          errors;
    int          cycles = 0;
    int unsigned seed;

    laser_link dut_i (.*);

    assign laser1_rx = laser1_tx | force1;
    assign laser2_rx = laser2_tx | force2;

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Expected output for one sent pair. A broken frame never arrives,
    // and a queue nobody drains keeps only its first QUEUE_DEPTH pairs
    function automatic void model_send(input lane_pair_t pair, input logic frame_ok);
        if (frame_ok && (pop_enable || model_q.size() < QUEUE_DEPTH)) begin
            model_q.push_back(pair);
        end
    endfunction

    task automatic expect_level(input logic actual, input logic level, input string what);
        assert (actual === level) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, actual, level);
        end
    endtask

    task automatic transmit(input lane_pair_t pair, input logic frame_ok);
        @(posedge clock);
        send      <= 1'b1;
        send_pair <= pair;
        model_send(pair, frame_ok);
        @(posedge clock);
        send      <= 1'b0;
        // Transmitter keeps its own copy of the pair
        send_pair <= lane_pair_t'(16'($urandom));
        @(negedge clock);
        expect_level(busy, 1'b1, "busy after send");
        while (busy) begin
            @(negedge clock);
        end
    endtask

    // Holds one rx line high from offset cycles after the edge that raises send
    task automatic inject_high(input int lane, input int offset, input int length);
        @(posedge clock);
        repeat (offset) @(posedge clock);
        if (lane == 1) begin
            force1 <= 1'b1;
        end else begin
            force2 <= 1'b1;
        end
        repeat (length) @(posedge clock);
        force1 <= 1'b0;
        force2 <= 1'b0;
    endtask

    task automatic wait_drained();
        while (model_q.size() != 0) begin
            @(negedge clock);
        end
    endtask

    task automatic finish_run(input logic timed_out);
        $display("Errors: %0d, timeout: %0d", errors, timed_out);
        if ((errors == 0) && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    always @(posedge clock) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            finish_run(1'b1);
        end
    end

    // Head of the queue is compared while pop is up, before the edge removes it
    always @(negedge clock) begin
        if (pop && !empty) begin
            assert (model_q.size() != 0) else begin
                errors++;
                $display("Pair %h came out at %0t although no pair was outstanding",
                         pair_out, $time);
            end
            if (model_q.size() != 0) begin
                expected = model_q.pop_front();
                assert (pair_out == expected) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: pair_out is %h, expected %h",
                             $time, pair_out, expected);
                end
            end
        end
        can_pop = pop_enable && !empty && !pop;
    end

    always @(posedge clock) begin
        pop <= can_pop;
    end

    initial begin
        seed       = $urandom(32'h6630);
        reset      = 1'b1;
        send       = 1'b0;
        send_pair  = '0;
        force1     = 1'b0;
        force2     = 1'b0;
        pop_enable = 1'b0;
        errors     = 0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        expect_level(busy, 1'b0, "busy after reset");
        expect_level(laser1_tx, 1'b0, "laser1_tx after reset");
        expect_level(laser2_tx, 1'b0, "laser2_tx after reset");
        expect_level(full, 1'b0, "full after reset");
        expect_level(overflow, 1'b0, "overflow after reset");
        expect_level(empty, 1'b1, "empty after reset");

        // Back to back loopback with the host popping
        pop_enable = 1'b1;
        repeat (LOOPBACK_PAIRS) begin
            transmit(lane_pair_t'(16'($urandom)), 1'b1);
        end
        wait_drained();

        // Flood the queue with nobody popping
        pop_enable = 1'b0;
        repeat (FLOOD_PAIRS) begin
            transmit(lane_pair_t'(16'($urandom)), 1'b1);
        end
        // Last frame has left the receivers within two bit periods
        repeat (2 * BIT_CLOCKS) @(negedge clock);
        expect_level(full, 1'b1, "full after flood");
        expect_level(overflow, 1'b1, "overflow after flood");
        pop_enable = 1'b1;
        wait_drained();
        repeat (2) @(negedge clock);
        expect_level(empty, 1'b1, "empty after drain");
        expect_level(full, 1'b0, "full after drain");

        // One-clock glitch on both idle lines, so an accepted glitch would form a pair
        fork
            inject_high(1, 0, 1);
            inject_high(2, 0, 1);
        join
        repeat (FRAME_BITS * BIT_CLOCKS) @(negedge clock);

        // One high sample in the middle of the low data bit 3 of lane 1
        fork
            transmit({8'hA5, 8'h3C}, 1'b1);
            inject_high(1, 1 + 4 * BIT_CLOCKS + BIT_CLOCKS / 2, 1);
        join
        wait_drained();

        // Broken stop bit on lane 2 leaves lane 1 with a stale byte
        fork
            transmit({8'h5A, 8'hC3}, 1'b0);
            inject_high(2, 1 + (FRAME_BITS - 1) * BIT_CLOCKS, BIT_CLOCKS);
        join
        transmit({8'h96, 8'h69}, 1'b1);
        wait_drained();
        repeat (2 * BIT_CLOCKS) @(negedge clock);
        finish_run(1'b0);
    end

endmodule
